//--- all.f
+incdir+.
core_pkg.sv
core_pipe_reg.sv
core_fetch.sv
core_decode_lane.sv
core_regfile.sv
core_scoreboard.sv
core_alu.sv
mcpu_core.sv
tb_mcpu_core.sv

//--- Makefile
# Verilator build and run of the mcpu_core testbench

VERILATOR ?= verilator
TOP       ?= tb_mcpu_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Done: errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_model.svh
`ifndef tb_model_svh
`define tb_model_svh

// Register state as the program sees it, r0 stays zero
logic [xlen-1:0] arch_regs [32];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// One slot from a hash of address and lane
function automatic logic [inst_w-1:0] make_slot(input logic [paddr_w-1:0] addr,
                                                input logic [1:0]         lane);
  logic [31:0] h;
  logic [3:0]  op;
  h  = xorshift32(xorshift32({addr, lane, 2'b11} ^ rng_seed));   // Never zero
  op = (h[9:8] == 2'b00) ? h[3:0] : 4'(h[3:0] % 4'd9);           // Invalid ops kept rare
  // Register fields only reach r0..r7 so dependencies are frequent
  return {op, 2'b00, h[12:10], 2'b00, h[15:13], 2'b00, h[18:16], h[31:19]};
endfunction

// Packet is a pure function of its address
function automatic logic [packet_w-1:0] make_packet(input logic [paddr_w-1:0] addr);
  logic [packet_w-1:0] p;
  logic [31:0]         h;
  h = xorshift32({addr, 4'b0101} ^ rng_seed);
  for (int l = 0; l < lanes_c; l++) begin
    p[l*inst_w +: inst_w] = (h[7] && l != 0) ? '0 : make_slot(addr, 2'(l));   // Half are 1-lane
  end
  return p;
endfunction

// Result of one slot by opcode number
function automatic logic [xlen-1:0] alu_ref(input logic [3:0]      op,
                                            input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
  case (op)
    4'd1, 4'd8: return a + b;   // ADD, ADDI
    4'd2:       return a - b;
    4'd3:       return a & b;
    4'd4:       return a | b;
    4'd5:       return a ^ b;
    4'd6:       return a << b[4:0];
    4'd7:       return a >> b[4:0];   // Logical
    default:    return '0;
  endcase
endfunction

`endif

//--- tb_mcpu_core.sv
`timescale 1ns/1ps

module tb_mcpu_core
  import core_pkg::*;
();

  localparam int          num_pkts       = 400;             // Packets fetched
  localparam int          ready_pct      = 75;              // I$ ready chance in percent
  localparam int          clk_period     = 100;
  localparam int          timeout_cycles = num_pkts * 20;
  localparam logic [31:0] rng_seed       = 32'hd7c5;

  logic                              clk = 1'b0;
  logic                              rst_n;
  logic [packet_w-1:0]               ic2f_packet;
  logic                              ic2f_ready;
  logic [paddr_w-1:0]                f2ic_paddr;
  logic                              f2ic_valid;
  logic                              wb_valid;
  logic [lanes_c-1:0]                wb_rd_we;
  logic [lanes_c-1:0][reg_num_w-1:0] wb_rd_num;
  logic [lanes_c-1:0][xlen-1:0]      wb_rd_data;

  logic [paddr_w-1:0] fetch_addr;   // Address the DUT must present
  logic [paddr_w-1:0] ret_addr;     // Next packet to retire
  logic [31:0]        rng;
  logic [31:0]        wmask_p1;     // rd writes of the last packet
  logic [31:0]        wmask_p2;     // and the one before
  int                 sent_cnt;
  int                 ret_cnt;
  int                 cycle_cnt;
  int                 err_cnt;
  int                 xfer_cycle_q[$];   // Transfer edge per packet in flight
  bit                 clean_q[$];        // No overlap with the two older packets

  logic [lanes_c-1:0]                exp_we;   // Settled on the falling edge
  logic [lanes_c-1:0][reg_num_w-1:0] exp_num;
  logic [lanes_c-1:0][xlen-1:0]      exp_data;
  logic                              exp_inflight;
  logic                              exp_clean;
  int                                exp_age;

  `include "tb_model.svh"

  mcpu_core #(.LANES(lanes_c), .NREGS(32)) u_mcpu_core (
    .clkrst_core_clk (clk),
    .rst_n           (rst_n),
    .ic2f_packet     (ic2f_packet),
    .ic2f_ready      (ic2f_ready),
    .f2ic_paddr      (f2ic_paddr),
    .f2ic_valid      (f2ic_valid),
    .wb_valid        (wb_valid),
    .wb_rd_we        (wb_rd_we),
    .wb_rd_num       (wb_rd_num),
    .wb_rd_data      (wb_rd_data)
  );

  always #(clk_period / 2) clk = ~clk;

  // Registers a packet reads or writes, r0 excluded since it never waits
  function automatic logic [31:0] reg_mask(input logic [packet_w-1:0] pkt, input bit wr_only);
    logic [31:0]       m;
    logic [inst_w-1:0] s;
    logic [3:0]        op;
    m = '0;
    for (int l = 0; l < lanes_c; l++) begin
      s  = pkt[l*inst_w +: inst_w];
      op = s[op_hi:op_lo];
      if (op >= 4'd1 && op <= 4'd8) begin
        m[s[rd_hi:rd_lo]] = 1'b1;
        if (!wr_only) begin
          m[s[rs_hi:rs_lo]] = 1'b1;
        end
        if (!wr_only && op != 4'd8) begin
          m[s[rt_hi:rt_lo]] = 1'b1;   // ADDI has no rt
        end
      end
    end
    m[0] = 1'b0;
    return m;
  endfunction

  always @(negedge clk) begin : expect_calc
    logic [packet_w-1:0] pkt;
    logic [inst_w-1:0]   s;
    logic [3:0]          op;
    logic [xlen-1:0]     b;
    pkt = make_packet(ret_addr);
    for (int l = 0; l < lanes_c; l++) begin   // All lanes read pre-packet values
      s           = pkt[l*inst_w +: inst_w];
      op          = s[op_hi:op_lo];
      b           = (op == 4'd8) ? xlen'(s[imm_hi:imm_lo]) : arch_regs[s[rt_hi:rt_lo]];
      exp_we[l]   = (op >= 4'd1) && (op <= 4'd8) && (s[rd_hi:rd_lo] != '0);
      exp_num[l]  = s[rd_hi:rd_lo];
      exp_data[l] = alu_ref(op, arch_regs[s[rs_hi:rs_lo]], b);
    end
    exp_inflight = (xfer_cycle_q.size() > 0);
    exp_clean    = exp_inflight && clean_q[0];
    exp_age      = exp_inflight ? cycle_cnt - xfer_cycle_q[0] : 0;
  end

  always @(posedge clk) begin : drive_and_retire
    logic [31:0]         r;
    logic [packet_w-1:0] pkt;
    int                  sent_next;
    r         = xorshift32(rng);
    sent_next = sent_cnt;
    rng       <= r;
    cycle_cnt <= cycle_cnt + 1;
    if (wb_valid) begin
      ret_cnt <= ret_cnt + 1;
      if (xfer_cycle_q.size() > 0) begin
        for (int l = 0; l < lanes_c; l++) begin   // Lane order, highest lane wins
          if (exp_we[l]) begin
            arch_regs[exp_num[l]] = exp_data[l];
          end
        end
        void'(xfer_cycle_q.pop_front());
        void'(clean_q.pop_front());
        ret_addr <= ret_addr + paddr_w'(1);
      end
    end
    if (f2ic_valid && ic2f_ready) begin   // Transfer on this edge
      pkt = make_packet(fetch_addr);
      xfer_cycle_q.push_back(cycle_cnt);
      clean_q.push_back((reg_mask(pkt, 1'b0) & (wmask_p1 | wmask_p2)) == '0);
      wmask_p1    <= reg_mask(pkt, 1'b1);
      wmask_p2    <= wmask_p1;
      fetch_addr  <= fetch_addr + paddr_w'(1);
      ic2f_packet <= make_packet(fetch_addr + paddr_w'(1));   // Next line ready in time
      sent_next   = sent_cnt + 1;
      sent_cnt    <= sent_next;
    end
    ic2f_ready <= (sent_next < num_pkts) && ((r % 32'd100) < 32'(ready_pct));
  end

  a_reset_quiet: assert property (@(posedge clk)
    (cycle_cnt >= 1) && (!rst_n || $rose(rst_n)) |-> !f2ic_valid && !wb_valid)
    else begin
      err_cnt++;
      $display("ERROR f2ic_valid/wb_valid: got %h/%h expected 0/0 around reset",
               $sampled(f2ic_valid), $sampled(wb_valid));
    end

  a_paddr: assert property (@(posedge clk) disable iff (!rst_n)
    f2ic_valid |-> f2ic_paddr == fetch_addr)
    else begin
      err_cnt++;
      $display("ERROR f2ic_paddr: got %h expected %h", $sampled(f2ic_paddr),
               $sampled(fetch_addr));
    end

  a_inflight: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> exp_inflight)
    else begin
      err_cnt++;
      $display("wb_valid came with no fetched packet left to retire");
    end

  a_we: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> wb_rd_we == exp_we)
    else begin
      err_cnt++;
      $display("ERROR wb_rd_we: got %h expected %h", $sampled(wb_rd_we), exp_we);
    end

  // Dependency-free packets never stall, so writeback is 3 edges after transfer
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid && exp_clean |-> exp_age == 3)
    else begin
      err_cnt++;
      $display("ERROR wb_valid latency: got %h expected %h", exp_age, 3);
    end

  for (genvar l = 0; l < lanes_c; l++) begin : g_lane_chk
    a_num: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid && exp_we[l] |-> wb_rd_num[l] == exp_num[l])
      else begin
        err_cnt++;
        $display("ERROR wb_rd_num[%0d]: got %h expected %h", l, $sampled(wb_rd_num[l]),
                 exp_num[l]);
      end
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid && exp_we[l] |-> wb_rd_data[l] == exp_data[l])
      else begin
        err_cnt++;
        $display("ERROR wb_rd_data[%0d]: got %h expected %h", l, $sampled(wb_rd_data[l]),
                 exp_data[l]);
      end
  end

  initial begin : main
    rst_n       = 1'b0;
    ic2f_ready  = 1'b0;
    ic2f_packet = make_packet('0);   // Line for the reset address
    fetch_addr  = '0;
    ret_addr    = '0;
    rng         = rng_seed;
    wmask_p1    = '0;
    wmask_p2    = '0;
    sent_cnt    = 0;
    ret_cnt     = 0;
    cycle_cnt   = 0;
    err_cnt     = 0;
    for (int i = 0; i < 32; i++) begin
      arch_regs[i] = '0;   // Matches regfile reset
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    wait (ret_cnt >= num_pkts);
    repeat (10) @(posedge clk);   // A late extra retirement shows up here
    if (ret_cnt != num_pkts) begin
      err_cnt++;
      $display("Retired %0d packets where %0d were fetched", ret_cnt, num_pkts);
    end
    $display("errors: %0d, packets sent: %0d, retired: %0d", err_cnt, sent_cnt, ret_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeout_cycles * clk_period);
    $display("Watchdog expired after %0d cycles with %0d of %0d packets retired",
             timeout_cycles, ret_cnt, num_pkts);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- mcpu_core.sv
`timescale 1ns/1ps

module mcpu_core
  import core_pkg::*;
#(
  parameter int LANES = lanes_c,   // Payload types are sized by lanes_c
  parameter int NREGS = 32
) (
  input  logic                            clkrst_core_clk,
  input  logic                            rst_n,
  input  logic [packet_w-1:0]             ic2f_packet,
  input  logic                            ic2f_ready,
  output logic [paddr_w-1:0]              f2ic_paddr,
  output logic                            f2ic_valid,
  output logic                            wb_valid,     // Retirement strobe
  output logic [LANES-1:0]                wb_rd_we,
  output logic [LANES-1:0][reg_num_w-1:0] wb_rd_num,
  output logic [LANES-1:0][xlen-1:0]      wb_rd_data
);

  f2d_payload_t   f2d_d;
  f2d_payload_t   f2d_q;
  d2ex_payload_t  d2ex_d;
  d2ex_payload_t  d2ex_q;
  ex2wb_payload_t ex2wb_d;
  ex2wb_payload_t ex2wb_q;

  logic dcd_valid;   // Packet sitting in decode
  logic ex_valid;    // Packet sitting in execute
  logic f2d_readyin, f2d_readyout, f2d_progress;
  logic d2ex_readyin, d2ex_readyout, d2ex_progress;
  logic ex2wb_readyin, ex2wb_readyout, ex2wb_progress;

  logic [LANES-1:0]                lane_stall;
  logic                            dcd_stall;
  logic [LANES-1:0][reg_num_w-1:0] rs_num;
  logic [LANES-1:0][reg_num_w-1:0] rt_num;
  logic [LANES-1:0][xlen-1:0]      rs_data;
  logic [LANES-1:0][xlen-1:0]      rt_data;
  logic [LANES-1:0]                issue_we;
  logic [LANES-1:0][reg_num_w-1:0] issue_num;
  logic [LANES-1:0][xlen-1:0]      alu_result;
  logic [NREGS-1:0]                pending;

  assign f2d_readyin    = ~dcd_valid | d2ex_progress;
  assign f2d_readyout   = f2ic_valid & ic2f_ready;   // I$ handshake
  assign f2d_progress   = f2d_readyin & f2d_readyout;

  assign d2ex_readyin   = ~ex_valid | ex2wb_progress;
  assign d2ex_readyout  = dcd_valid & ~dcd_stall;
  assign d2ex_progress  = d2ex_readyin & d2ex_readyout;

  assign ex2wb_readyin  = 1'b1;       // Writeback never pushes back
  assign ex2wb_readyout = ex_valid;   // Single-cycle ALUs
  assign ex2wb_progress = ex2wb_readyin & ex2wb_readyout;

  assign dcd_stall = |lane_stall;

  core_fetch u_fetch (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .room            (f2d_readyin),
    .ic2f_ready      (ic2f_ready),
    .f2ic_valid      (f2ic_valid),
    .f2ic_paddr      (f2ic_paddr)
  );

  assign f2d_d.packet = ic2f_packet;
  assign f2d_d.paddr  = f2ic_paddr;

  core_pipe_reg #(.T(f2d_payload_t)) u_f2d_reg (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .en              (f2d_readyin),
    .valid_in        (f2d_readyout),
    .d               (f2d_d),
    .valid_out       (dcd_valid),
    .q               (f2d_q)
  );

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    core_decode_lane #(.NREGS(NREGS)) u_dec (
      .inst    (f2d_q.packet[g*inst_w +: inst_w]),   // Lane 0 in low bits
      .rs_data (rs_data[g]),
      .rt_data (rt_data[g]),
      .pending (pending),
      .rs_num  (rs_num[g]),
      .rt_num  (rt_num[g]),
      .uop     (d2ex_d[g]),
      .stall   (lane_stall[g])
    );

    assign issue_we[g]  = d2ex_d[g].rd_we;
    assign issue_num[g] = d2ex_d[g].rd_num;

    core_alu u_alu (
      .uop    (d2ex_q[g]),
      .result (alu_result[g])
    );

    assign wb_rd_we[g]   = wb_valid & ex2wb_q.rd_we[g];   // Also the regfile write enable
    assign wb_rd_num[g]  = ex2wb_q.rd_num[g];
    assign wb_rd_data[g] = ex2wb_q.result[g];
  end

  core_regfile #(.LANES(LANES), .NREGS(NREGS)) u_regfile (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .rs_num          (rs_num),
    .rt_num          (rt_num),
    .wr_en           (wb_rd_we),
    .wr_num          (wb_rd_num),
    .wr_data         (wb_rd_data),
    .rs_data         (rs_data),
    .rt_data         (rt_data)
  );

  core_scoreboard #(.LANES(LANES), .NREGS(NREGS)) u_scoreboard (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .issue           (d2ex_progress),
    .issue_we        (issue_we),
    .issue_num       (issue_num),
    .wb_we           (wb_rd_we),   // Clear lands with the regfile write
    .wb_num          (wb_rd_num),
    .pending         (pending)
  );

  core_pipe_reg #(.T(d2ex_payload_t)) u_d2ex_reg (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .en              (d2ex_readyin),
    .valid_in        (d2ex_readyout),
    .d               (d2ex_d),
    .valid_out       (ex_valid),
    .q               (d2ex_q)
  );

  always_comb begin
    ex2wb_d = '0;
    for (int l = 0; l < LANES; l++) begin
      ex2wb_d.rd_we[l]  = d2ex_q[l].rd_we;
      ex2wb_d.rd_num[l] = d2ex_q[l].rd_num;
      ex2wb_d.result[l] = alu_result[l];
    end
  end

  core_pipe_reg #(.T(ex2wb_payload_t)) u_ex2wb_reg (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .en              (ex2wb_readyin),
    .valid_in        (ex2wb_readyout),
    .d               (ex2wb_d),
    .valid_out       (wb_valid),
    .q               (ex2wb_q)
  );

  // Packets reach decode in fetch order with no gaps or repeats
  a_fetch_order: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
    d2ex_progress && f2d_progress |=> f2d_q.paddr == $past(f2d_q.paddr) + paddr_w'(1))
    else $error("ERROR: decode paddr %h does not follow %h", f2d_q.paddr,
                $past(f2d_q.paddr));

endmodule

//--- core_alu.sv
`timescale 1ns/1ps

module core_alu
  import core_pkg::*;
(
  input  lane_uop_t       uop,
  output logic [xlen-1:0] result
);

  logic [4:0] shamt;   // Only low five bits of rt count

  assign shamt = uop.opb[4:0];

  always_comb begin
    case (uop.op)
      op_add, op_addi: begin
        result = uop.opa + uop.opb;   // opb already holds imm13 for ADDI
      end
      op_sub: begin
        result = uop.opa - uop.opb;
      end
      op_and: begin
        result = uop.opa & uop.opb;
      end
      op_or: begin
        result = uop.opa | uop.opb;
      end
      op_xor: begin
        result = uop.opa ^ uop.opb;
      end
      op_shl: begin
        result = uop.opa << shamt;
      end
      op_shr: begin
        result = uop.opa >> shamt;   // Zero fill
      end
      default: begin
        result = '0;   // NOP, rd_we is low anyway
      end
    endcase
  end

endmodule

//--- core_scoreboard.sv
`timescale 1ns/1ps

module core_scoreboard
  import core_pkg::*;
#(
  parameter int LANES = lanes_c,
  parameter int NREGS = 32
) (
  input  logic                            clkrst_core_clk,
  input  logic                            rst_n,
  input  logic                            issue,       // Decode to execute progress
  input  logic [LANES-1:0]                issue_we,
  input  logic [LANES-1:0][reg_num_w-1:0] issue_num,
  input  logic [LANES-1:0]                wb_we,       // Lanes writing the regfile now
  input  logic [LANES-1:0][reg_num_w-1:0] wb_num,
  output logic [NREGS-1:0]                pending
);

  logic [NREGS-1:0] set_mask;
  logic [NREGS-1:0] clr_mask;

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    for (int l = 0; l < LANES; l++) begin
      if (issue && issue_we[l]) begin
        set_mask[issue_num[l]] = 1'b1;   // Same rd in two lanes sets once
      end
      if (wb_we[l]) begin
        clr_mask[wb_num[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clkrst_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr_mask) | set_mask;
    end
  end

  // Decode stall on rd must keep an issue off a register still in flight
  for (genvar l = 0; l < LANES; l++) begin : g_chk
    a_no_reissue: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
      issue && issue_we[l] |-> !pending[issue_num[l]])
      else $error("ERROR: lane %0d issued to pending r%0d", l, issue_num[l]);
  end

endmodule

//--- core_regfile.sv
`timescale 1ns/1ps

module core_regfile
  import core_pkg::*;
#(
  parameter int LANES = lanes_c,
  parameter int NREGS = 32
) (
  input  logic                            clkrst_core_clk,
  input  logic                            rst_n,
  input  logic [LANES-1:0][reg_num_w-1:0] rs_num,
  input  logic [LANES-1:0][reg_num_w-1:0] rt_num,
  input  logic [LANES-1:0]                wr_en,     // Already qualified by wb_valid
  input  logic [LANES-1:0][reg_num_w-1:0] wr_num,
  input  logic [LANES-1:0][xlen-1:0]      wr_data,
  output logic [LANES-1:0][xlen-1:0]      rs_data,
  output logic [LANES-1:0][xlen-1:0]      rt_data
);

  logic [xlen-1:0] regs [NREGS];

  always_ff @(posedge clkrst_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NREGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < LANES; l++) begin   // Later lane overrides, highest wins
        if (wr_en[l] && (wr_num[l] != '0)) begin
          regs[wr_num[l]] <= wr_data[l];
        end
      end
    end
  end

  // Two read ports per lane, no bypass from writeback
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      rs_data[l] = (rs_num[l] == '0) ? '0 : regs[rs_num[l]];
      rt_data[l] = (rt_num[l] == '0) ? '0 : regs[rt_num[l]];
    end
  end

endmodule

//--- core_decode_lane.sv
`timescale 1ns/1ps

module core_decode_lane
  import core_pkg::*;
#(
  parameter int NREGS = 32
) (
  input  logic [inst_w-1:0]    inst,
  input  logic [xlen-1:0]      rs_data,    // From regfile, pre-packet value
  input  logic [xlen-1:0]      rt_data,
  input  logic [NREGS-1:0]     pending,    // Scoreboard bitmap
  output logic [reg_num_w-1:0] rs_num,
  output logic [reg_num_w-1:0] rt_num,
  output lane_uop_t            uop,
  output logic                 stall
);

  logic [3:0]           op_raw;
  logic [reg_num_w-1:0] rd_num;
  logic [xlen-1:0]      imm_ext;
  logic                 legal;     // Opcode 0..8
  logic                 is_imm;    // ADDI takes imm13 for operand b
  logic                 uses_rs;
  logic                 uses_rt;

  assign op_raw  = inst[op_hi:op_lo];
  assign rd_num  = inst[rd_hi:rd_lo];
  assign rs_num  = inst[rs_hi:rs_lo];
  assign rt_num  = inst[rt_hi:rt_lo];   // Read even for ADDI, harmless
  assign imm_ext = {{(xlen-imm_w){1'b0}}, inst[imm_hi:imm_lo]};

  assign legal   = (op_raw <= op_last);
  assign is_imm  = (op_raw == op_addi);
  assign uses_rs = legal && (op_raw != op_nop);   // Every real op reads rs
  assign uses_rt = uses_rs && !is_imm;

  always_comb begin
    uop.op     = legal ? opcode_t'(op_raw) : op_nop;   // 9..15 become NOP
    uop.rd_num = rd_num;
    uop.rd_we  = uses_rs && (rd_num != '0);            // r0 never written
    uop.opa    = rs_data;
    uop.opb    = is_imm ? imm_ext : rt_data;
  end

  // Hold the lane while an older packet still owns a register it touches.
  // Checking rd too keeps writes to one register in order.
  assign stall = (uses_rs && pending[rs_num])
              || (uses_rt && pending[rt_num])
              || (uop.rd_we && pending[rd_num]);

endmodule

//--- core_fetch.sv
`timescale 1ns/1ps

module core_fetch
  import core_pkg::*;
(
  input  logic               clkrst_core_clk,
  input  logic               rst_n,
  input  logic               room,         // Decode register can take a packet
  input  logic               ic2f_ready,
  output logic               f2ic_valid,
  output logic [paddr_w-1:0] f2ic_paddr
);

  logic run_q;   // High from the first edge after reset release
  logic xfer;    // Packet accepted by I$ this edge

  assign f2ic_valid = room & run_q;   // Request only when decode has room
  assign xfer       = f2ic_valid & ic2f_ready;

  always_ff @(posedge clkrst_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q      <= 1'b0;
      f2ic_paddr <= '0;   // Fetch starts at packet 0
    end else begin
      run_q <= 1'b1;
      if (xfer) begin
        f2ic_paddr <= f2ic_paddr + paddr_w'(1);   // Strictly sequential
      end
    end
  end

  // A waiting request stays up with its address until the cache takes it
  a_paddr_hold: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
    f2ic_valid && !ic2f_ready |=> f2ic_valid && $stable(f2ic_paddr))
    else $error("ERROR: request dropped or f2ic_paddr moved while pending, now %h",
                f2ic_paddr);

endmodule

//--- core_pipe_reg.sv
`timescale 1ns/1ps

module core_pipe_reg #(
  parameter type T = logic   // Stage payload
) (
  input  logic clkrst_core_clk,
  input  logic rst_n,
  input  logic en,          // Slot empty or draining this edge
  input  logic valid_in,    // Upstream readyout
  input  T     d,
  output logic valid_out,
  output T     q
);

  always_ff @(posedge clkrst_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (en) begin
      valid_out <= valid_in;   // Bubble if upstream not ready
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (en) begin
      q <= d;   // Payload only, valid qualifies it
    end
  end

  // Upstream must hand over a fully defined payload whenever it marks it valid
  a_q_known: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
    valid_out |-> !$isunknown(q))
    else $error("ERROR: stage payload unknown while valid_out high");

endmodule

//--- core_pkg.sv
package core_pkg;

  localparam int xlen      = 32;                 // Data word
  localparam int inst_w    = 32;                 // One instruction slot
  localparam int reg_num_w = 5;                  // Register index
  localparam int paddr_w   = 28;                 // Packet index, not a byte address
  localparam int lanes_c   = 4;                  // Default issue width
  localparam int packet_w  = lanes_c * inst_w;   // 128-bit I$ line
  localparam int imm_w     = 13;                 // ADDI immediate, zero-extended

  // Slot fields, lane 0 sits in packet bits 31:0
  localparam int op_hi  = 31;
  localparam int op_lo  = 28;
  localparam int rd_hi  = 27;
  localparam int rd_lo  = 23;
  localparam int rs_hi  = 22;
  localparam int rs_lo  = 18;
  localparam int rt_hi  = 17;
  localparam int rt_lo  = 13;
  localparam int imm_hi = 12;
  localparam int imm_lo = 0;

  typedef enum logic [3:0] {
    op_nop  = 4'd0,   // No write
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_xor  = 4'd5,
    op_shl  = 4'd6,   // Amount from rt[4:0]
    op_shr  = 4'd7,   // Logical
    op_addi = 4'd8    // rs + imm13
  } opcode_t;

  localparam logic [3:0] op_last = 4'd8;   // Above this is invalid

  // One decoded slot as it leaves decode
  typedef struct packed {
    opcode_t              op;       // Invalid already folded to NOP
    logic [reg_num_w-1:0] rd_num;
    logic                 rd_we;    // Low for NOP, invalid, rd == r0
    logic [xlen-1:0]      opa;      // rs value
    logic [xlen-1:0]      opb;      // rt value or imm13
  } lane_uop_t;

  typedef struct packed {
    logic [packet_w-1:0] packet;
    logic [paddr_w-1:0]  paddr;     // Kept for ordering checks
  } f2d_payload_t;

  // Execute stage input, one uop per lane
  typedef lane_uop_t [lanes_c-1:0] d2ex_payload_t;

  // Writeback stage input
  typedef struct packed {
    logic [lanes_c-1:0]                rd_we;
    logic [lanes_c-1:0][reg_num_w-1:0] rd_num;
    logic [lanes_c-1:0][xlen-1:0]      result;
  } ex2wb_payload_t;

endpackage
